/* src/exec_pkg.sv */
/*
 * Execute lane package.
 * Holds the widths, vector types, completion flag layout and the
 * opcode encoding shared by the decode, ALU and writeback stages.
 */

package exec_pkg;

	// widths are fixed by the instruction set.
	localparam int DATA_W  = 32;
	localparam int IMMD_W  = 16;
	localparam int SHAMT_W = 5;
	localparam int TAG_W   = 6;
	localparam int FLAGS_W = 2;
	localparam int OP_W    = 6;

	// completion flag bit positions.
	localparam int FLAG_EXEC  = 1; // set for every real operation.
	localparam int FLAG_CARRY = 0; // carry-out of signed add/sub only.

	typedef logic [DATA_W-1:0]  data_t;
	typedef logic [IMMD_W-1:0]  immd_t;
	typedef logic [SHAMT_W-1:0] shamt_t;
	typedef logic [TAG_W-1:0]   tag_t;
	typedef logic [FLAGS_W-1:0] flags_t;

	// Opcodes that are not listed here execute as a NOP.
	typedef enum logic [OP_W-1:0] {
		ADD    = 6'h00,
		ADDI   = 6'h01,
		ADDU   = 6'h02,
		ADDIU  = 6'h03,
		SUB    = 6'h04,
		SUBU   = 6'h05,
		AND_OP = 6'h06,
		ANDI   = 6'h07,
		OR_OP  = 6'h08,
		ORI    = 6'h09,
		XOR_OP = 6'h0a,
		XORI   = 6'h0b,
		NOR_OP = 6'h0c,
		SLL    = 6'h0d,
		SLLV   = 6'h0e,
		SRL    = 6'h0f,
		SRLV   = 6'h10,
		SRA    = 6'h11,
		SRAV   = 6'h12,
		SLT    = 6'h13,
		SLTI   = 6'h14,
		SLTU   = 6'h15,
		SLTIU  = 6'h16,
		LUI    = 6'h17,
		NOP    = 6'h18
	} alu_op_e;

endpackage

/* src/exec_if.sv */
/*
 * Execute lane stage interface.
 * Carries the decoded instruction from the decode register through
 * the combinational ALU to the writeback register, plus the ready
 * that flows back from writeback.
 */

`timescale 1ns/10ps

interface exec_if
	import exec_pkg::*;
();

	logic    valid;
	alu_op_e opcode;
	data_t   operand_a;
	data_t   operand_b;
	shamt_t  shamt;
	tag_t    tag;
	data_t   result;    // combinational ALU output.
	flags_t  flags;
	logic    ready;     // writeback can take the current instruction.

	modport decode_mp (output valid, opcode, operand_a, operand_b, shamt, tag, input ready);

	modport alu_mp (input opcode, operand_a, operand_b, shamt, output result, flags);

	modport wb_mp (input valid, tag, result, flags, output ready);

endinterface

/* src/issue_decode.sv */
/*
 * Issue and decode stage.
 * Accepts issued instructions under valid/ready, extends the immediate,
 * picks the shift source and registers uniform operands for the ALU.
 */

`timescale 1ns/10ps

module issue_decode
	import exec_pkg::*;
(
	input  logic      clk_i,
	input  logic      rst_i,
	input  logic      in_valid_i,
	output logic      in_ready_o,
	input  alu_op_e   in_opcode_i,
	input  data_t     in_data1_i,
	input  data_t     in_data2_i,
	input  immd_t     in_immd_i,
	input  tag_t      in_tag_i,
	exec_if.decode_mp ex
);

	logic    valid_q;
	logic    accept;
	data_t   imm_sext;
	data_t   imm_zext;
	data_t   opa_d;
	data_t   opb_d;
	shamt_t  shamt_d;
	alu_op_e opcode_q;
	data_t   opa_q;
	data_t   opb_q;
	shamt_t  shamt_q;
	tag_t    tag_q;

	assign in_ready_o = !valid_q || ex.ready; // empty, or the entry moves on this cycle.
	assign accept     = in_valid_i && in_ready_o;

	assign imm_sext = {{(DATA_W-IMMD_W){in_immd_i[IMMD_W-1]}}, in_immd_i};
	assign imm_zext = {{(DATA_W-IMMD_W){1'b0}}, in_immd_i};

	// Register forms pass data1/data2 through unchanged.
	always_comb
	begin
		opa_d   = in_data1_i;
		opb_d   = in_data2_i;
		shamt_d = '0;
		case (in_opcode_i)
			ADDI, ADDIU, SLTI:           opb_d = imm_sext;
			ANDI, ORI, XORI, SLTIU, LUI: opb_d = imm_zext;
			SLL, SRL, SRA:               shamt_d = in_immd_i[SHAMT_W-1:0];
			SLLV, SRLV, SRAV:
			begin
				// variable shifts move data2 by the low bits of data1.
				opa_d   = in_data2_i;
				shamt_d = in_data1_i[SHAMT_W-1:0];
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			valid_q <= 1'b0;
		else if (in_ready_o)
			valid_q <= in_valid_i;
	end

	always_ff @(posedge clk_i)
	begin
		if (accept)
		begin
			opcode_q <= in_opcode_i;
			opa_q    <= opa_d;
			opb_q    <= opb_d;
			shamt_q  <= shamt_d;
			tag_q    <= in_tag_i;
		end
	end

	assign ex.valid     = valid_q;
	assign ex.opcode    = opcode_q;
	assign ex.operand_a = opa_q;
	assign ex.operand_b = opb_q;
	assign ex.shamt     = shamt_q;
	assign ex.tag       = tag_q;

endmodule

/* src/simple_alu.sv */
/*
 * Simple integer ALU.
 * Purely combinational. Produces the result word and the completion
 * flags (executed, carry) from the decoded operands and shift amount.
 */

`timescale 1ns/10ps

module simple_alu
	import exec_pkg::*;
(
	exec_if.alu_mp ex
);

	logic [DATA_W:0] sum;
	logic [DATA_W:0] diff;
	data_t           result;
	logic            executed;
	logic            carry;

	// 33-bit add and subtract whose top bit is the carry-out.
	assign sum  = {1'b0, ex.operand_a} + {1'b0, ex.operand_b};
	assign diff = {1'b0, ex.operand_a} - {1'b0, ex.operand_b};

	always_comb
	begin
		result   = '0;
		executed = 1'b1;
		carry    = 1'b0;
		case (ex.opcode)
			ADD, ADDI:
			begin
				result = sum[DATA_W-1:0];
				carry  = sum[DATA_W];
			end
			ADDU, ADDIU:
			begin
				result = sum[DATA_W-1:0]; // unsigned forms report no carry.
			end
			SUB:
			begin
				result = diff[DATA_W-1:0];
				carry  = diff[DATA_W];
			end
			SUBU:
			begin
				result = diff[DATA_W-1:0];
			end
			AND_OP, ANDI:
			begin
				result = ex.operand_a & ex.operand_b;
			end
			OR_OP, ORI:
			begin
				result = ex.operand_a | ex.operand_b;
			end
			XOR_OP, XORI:
			begin
				result = ex.operand_a ^ ex.operand_b;
			end
			NOR_OP:
			begin
				result = ~(ex.operand_a | ex.operand_b);
			end
			SLL, SLLV:
			begin
				result = ex.operand_a << ex.shamt;
			end
			SRL, SRLV:
			begin
				result = ex.operand_a >> ex.shamt;
			end
			SRA, SRAV:
			begin
				result = $signed(ex.operand_a) >>> ex.shamt; // sign bit fills from the top.
			end
			SLT, SLTI:
			begin
				result = data_t'($signed(ex.operand_a) < $signed(ex.operand_b));
			end
			SLTU, SLTIU:
			begin
				result = data_t'(ex.operand_a < ex.operand_b);
			end
			LUI:
			begin
				// the immediate arrives zero-extended in operand_b.
				result = {ex.operand_b[IMMD_W-1:0], {(DATA_W-IMMD_W){1'b0}}};
			end
			default:
			begin
				// NOP and any unlisted code complete with nothing done.
				executed = 1'b0;
			end
		endcase
	end

	always_comb
	begin
		ex.flags             = '0;
		ex.flags[FLAG_EXEC]  = executed;
		ex.flags[FLAG_CARRY] = carry;
	end

	assign ex.result = result;

endmodule

/* src/writeback_buffer.sv */
/*
 * Writeback buffer.
 * One-entry output register for result, flags and tag. Holds its entry
 * while the consumer stalls and passes back-pressure to decode.
 */

`timescale 1ns/10ps

module writeback_buffer
	import exec_pkg::*;
(
	input  logic   clk_i,
	input  logic   rst_i,
	exec_if.wb_mp  ex,
	output logic   out_valid_o,
	input  logic   out_ready_i,
	output data_t  out_result_o,
	output flags_t out_flags_o,
	output tag_t   out_tag_o
);

	logic   full_q;
	logic   take;
	data_t  result_q;
	flags_t flags_q;
	tag_t   tag_q;

	// Free when empty or when the consumer drains the entry this cycle.
	assign ex.ready = !full_q || out_ready_i;
	assign take     = ex.valid && ex.ready;

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			full_q <= 1'b0;
		else if (ex.ready)
			full_q <= ex.valid; // refill or go empty.
	end

	always_ff @(posedge clk_i)
	begin
		if (take)
		begin
			result_q <= ex.result;
			flags_q  <= ex.flags;
			tag_q    <= ex.tag;
		end
	end

	assign out_valid_o  = full_q;
	assign out_result_o = result_q;
	assign out_flags_o  = flags_q;
	assign out_tag_o    = tag_q;

endmodule

/* src/exec_lane_top.sv */
/*
 * Integer execute lane.
 * Decode register, combinational ALU and writeback register joined by
 * the stage interface. Two cycles from accept to output valid.
 */

`timescale 1ns/10ps

module exec_lane_top
	import exec_pkg::*;
(
	input  logic    clk_i,
	input  logic    rst_i,
	input  logic    in_valid_i,
	output logic    in_ready_o,
	input  alu_op_e in_opcode_i,
	input  data_t   in_data1_i,
	input  data_t   in_data2_i,
	input  immd_t   in_immd_i,
	input  tag_t    in_tag_i,
	output logic    out_valid_o,
	input  logic    out_ready_i,
	output data_t   out_result_o,
	output flags_t  out_flags_o,
	output tag_t    out_tag_o
);

	exec_if ex ();

	issue_decode u_decode (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.in_valid_i  (in_valid_i),
		.in_ready_o  (in_ready_o),
		.in_opcode_i (in_opcode_i),
		.in_data1_i  (in_data1_i),
		.in_data2_i  (in_data2_i),
		.in_immd_i   (in_immd_i),
		.in_tag_i    (in_tag_i),
		.ex          (ex.decode_mp)
	);

	simple_alu u_alu (
		.ex (ex.alu_mp)
	);

	writeback_buffer u_wb (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.ex           (ex.wb_mp),
		.out_valid_o  (out_valid_o),
		.out_ready_i  (out_ready_i),
		.out_result_o (out_result_o),
		.out_flags_o  (out_flags_o),
		.out_tag_o    (out_tag_o)
	);

endmodule

/* test/alu_model.svh */
/*
 * Reference model for the execute lane.
 * Computes the expected result and completion flags straight from the
 * opcode and the raw issued operands, before any decode.
 */

`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

function automatic data_t expected_result(alu_op_e op, data_t d1, data_t d2, immd_t im);
	data_t se;
	data_t ze;
	data_t r;
	se = {{16{im[15]}}, im};
	ze = {16'h0000, im};
	case (op)
		ADD, ADDU:   r = d1 + d2;
		ADDI, ADDIU: r = d1 + se;
		SUB, SUBU:   r = d1 - d2;
		AND_OP:      r = d1 & d2;
		ANDI:        r = d1 & ze;
		OR_OP:       r = d1 | d2;
		ORI:         r = d1 | ze;
		XOR_OP:      r = d1 ^ d2;
		XORI:        r = d1 ^ ze;
		NOR_OP:      r = ~(d1 | d2);
		SLL:         r = d1 << im[4:0];
		SRL:         r = d1 >> im[4:0];
		SRA:         r = $signed(d1) >>> im[4:0];
		SLLV:        r = d2 << d1[4:0]; // register shifts move data2.
		SRLV:        r = d2 >> d1[4:0];
		SRAV:        r = $signed(d2) >>> d1[4:0];
		SLT:         r = ($signed(d1) < $signed(d2)) ? 32'd1 : 32'd0;
		SLTI:        r = ($signed(d1) < $signed(se)) ? 32'd1 : 32'd0;
		SLTU:        r = (d1 < d2) ? 32'd1 : 32'd0;
		SLTIU:       r = (d1 < ze) ? 32'd1 : 32'd0;
		LUI:         r = {im, 16'h0000};
		default:     r = '0;
	endcase
	return r;
endfunction

function automatic flags_t completion_flags(alu_op_e op, data_t d1, data_t d2, immd_t im);
	logic [32:0] wide;
	flags_t      f;
	f    = 2'b10; // executed, no carry.
	wide = '0;
	case (op)
		ADD:  wide = {1'b0, d1} + {1'b0, d2};
		ADDI: wide = {1'b0, d1} + {1'b0, {{16{im[15]}}, im}};
		SUB:  wide = {1'b0, d1} - {1'b0, d2};
		NOP:  f = 2'b00;
		default:
		begin
			// codes past the last opcode do nothing at all.
			if (op > NOP)
				f = 2'b00;
		end
	endcase
	f[0] = wide[32];
	return f;
endfunction

`endif

/* test/exec_lane_tb.sv */
/*
 * Testbench for the integer execute lane.
 * Directed tests per opcode group, then a random stream under random
 * output back-pressure, all checked against the reference model.
 */

`timescale 1ns/10ps

module exec_lane_tb
	import exec_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	// 1 + 20 + 18 + 18 + 12 directed instructions plus the random stream.
	localparam int TOTAL_OPS  = 269;

	logic    clk_i;
	logic    rst_i;
	logic    in_valid_i;
	logic    in_ready_o;
	alu_op_e in_opcode_i;
	data_t   in_data1_i;
	data_t   in_data2_i;
	immd_t   in_immd_i;
	tag_t    in_tag_i;
	logic    out_valid_o;
	logic    out_ready_i;
	data_t   out_result_o;
	flags_t  out_flags_o;
	tag_t    out_tag_o;

	data_t  exp_result_q[$]; // expected outputs in issue order.
	flags_t exp_flags_q[$];
	tag_t   exp_tag_q[$];
	tag_t   next_tag     = '0;
	bit     random_ready = 1'b0;
	int     op_count     = 0; // instructions accepted so far.
	int     done_count   = 0; // instructions that left the output.
	int     check_count  = 0;
	int     error_count  = 0;
	int     test_base    = 0;

	`include "alu_model.svh"

	exec_lane_top dut (.*);

	initial
	begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD/2) clk_i = ~clk_i;
	end

	initial
	begin
		#((TOTAL_OPS * 10 + 1000) * CLK_PERIOD);
		$display("Timed out after %0d cycles, the tests never finished.", TOTAL_OPS * 10 + 1000);
		$display("Simulation failed");
		$finish;
	end

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp)
		begin
			error_count++;
			$display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic collect_output();
		if (exp_tag_q.size() == 0)
		begin
			error_count++;
			$display("Output with tag %0d at %0t had no instruction waiting for it.",
				out_tag_o, $time);
		end
		else
		begin
			check("out_result_o", out_result_o, exp_result_q.pop_front());
			check("out_flags_o", out_flags_o, exp_flags_q.pop_front());
			check("out_tag_o", out_tag_o, exp_tag_q.pop_front());
			done_count++;
		end
	endtask

	// output side drives ready on the falling edge and samples a quarter cycle later.
	initial
	begin
		out_ready_i = 1'b1;
		forever
		begin
			@(negedge clk_i);
			out_ready_i = random_ready ? 1'($urandom_range(1, 0)) : 1'b1;
			#(CLK_PERIOD/4);
			if (!rst_i)
			begin
				// input stalls only with both registers full and the output blocked.
				check("in_ready_o", in_ready_o,
					!((op_count - done_count) == 2 && !out_ready_i));
				if (out_valid_o && out_ready_i)
					collect_output();
			end
		end
	end

	task automatic send_op(input alu_op_e op, input data_t d1, input data_t d2, input immd_t im);
		@(negedge clk_i);
		in_valid_i  = 1'b1;
		in_opcode_i = op;
		in_data1_i  = d1;
		in_data2_i  = d2;
		in_immd_i   = im;
		in_tag_i    = next_tag;
		#(CLK_PERIOD/4);
		while (!in_ready_o)
		begin
			@(negedge clk_i);
			#(CLK_PERIOD/4);
		end
		exp_result_q.push_back(expected_result(op, d1, d2, im));
		exp_flags_q.push_back(completion_flags(op, d1, d2, im));
		exp_tag_q.push_back(next_tag);
		next_tag++;
		@(posedge clk_i); // the accept edge.
		op_count++;
	endtask

	task automatic drain();
		@(negedge clk_i);
		in_valid_i = 1'b0;
		while (exp_tag_q.size() != 0)
			@(negedge clk_i);
		repeat (2) @(negedge clk_i);
	endtask

	task automatic report_test(input string name);
		$display("%s finished with %0d errors", name, error_count - test_base);
		test_base = error_count;
	endtask

	task automatic reset_and_latency();
		check("in_ready_o", in_ready_o, 1);
		check("out_valid_o", out_valid_o, 0);
		send_op(ADD, 32'h0000_1234, 32'h0000_0100, 16'h0000);
		@(negedge clk_i);
		in_valid_i = 1'b0;
		check("out_valid_o", out_valid_o, 0); // still in the decode register.
		@(negedge clk_i);
		check("out_valid_o", out_valid_o, 1);
		drain();
		report_test("reset and latency");
	endtask

	task automatic add_sub_carry();
		alu_op_e ops[4];
		data_t   a_vals[3];
		data_t   b_vals[3];
		immd_t   imms[2];
		int      j;
		int      k;
		ops    = '{ADD, ADDU, SUB, SUBU};
		a_vals = '{32'hffff_fff0, 32'h0000_0005, 32'h0000_0003};
		b_vals = '{32'h0000_0020, 32'h0000_0003, 32'h0000_0005};
		imms   = '{16'h0020, 16'hfffe}; // the second one is -2.
		foreach (ops[i])
			foreach (a_vals[n])
				send_op(ops[i], a_vals[n], b_vals[n], 16'h0000);
		for (j = 0; j < 2; j++)
			for (k = 0; k < 2; k++)
			begin
				send_op(ADDI, a_vals[j], 32'h0, imms[k]);
				send_op(ADDIU, a_vals[j], 32'h0, imms[k]);
			end
		drain();
		report_test("add and subtract");
	endtask

	task automatic logic_ops();
		alu_op_e ops[9];
		data_t   d1s[2];
		data_t   d2s[2];
		immd_t   imms[2];
		ops  = '{AND_OP, ANDI, OR_OP, ORI, XOR_OP, XORI, NOR_OP, LUI, NOP};
		d1s  = '{32'hf0f0_a5a5, 32'h0f0f_ffff};
		d2s  = '{32'h1234_5678, 32'hffff_0000};
		imms = '{16'h8f0f, 16'hffff}; // bit 15 set in both.
		foreach (ops[i])
			foreach (d1s[n])
				send_op(ops[i], d1s[n], d2s[n], imms[n]);
		drain();
		report_test("logic, lui and nop");
	endtask

	task automatic shift_ops();
		alu_op_e imm_ops[3];
		alu_op_e reg_ops[3];
		immd_t   amts[3];
		data_t   value;
		imm_ops = '{SLL, SRL, SRA};
		reg_ops = '{SLLV, SRLV, SRAV};
		amts    = '{16'h0000, 16'h0001, 16'h001f};
		value   = 32'hc000_0003;
		foreach (imm_ops[i])
			foreach (amts[n])
			begin
				send_op(imm_ops[i], value, 32'h0, amts[n]);
				send_op(reg_ops[i], 32'hffff_ffe0 | amts[n], value, 16'h0000);
			end
		drain();
		report_test("shifts");
	endtask

	task automatic compare_ops();
		alu_op_e ops[4];
		data_t   d1s[3];
		data_t   d2s[3];
		immd_t   imms[3];
		ops  = '{SLT, SLTI, SLTU, SLTIU};
		d1s  = '{32'hffff_fffe, 32'h0000_0003, 32'h7fff_ffff};
		d2s  = '{32'h0000_0003, 32'hffff_fffe, 32'h8000_0000};
		imms = '{16'h0003, 16'hfffe, 16'h8000};
		foreach (ops[i])
			foreach (d1s[n])
				send_op(ops[i], d1s[n], d2s[n], imms[n]);
		drain();
		report_test("set less than");
	endtask

	task automatic random_stream();
		int n;
		@(posedge clk_i);
		random_ready = 1'b1;
		// code 25 lies past the last opcode and must act as a NOP.
		for (n = 0; n < 200; n++)
			send_op(alu_op_e'($urandom_range(25, 0)), $urandom, $urandom, immd_t'($urandom));
		drain();
		@(posedge clk_i);
		random_ready = 1'b0;
		report_test("random stream");
	endtask

	initial
	begin
		void'($urandom(32'hd74745aa));
		rst_i       = 1'b1;
		in_valid_i  = 1'b0;
		in_opcode_i = NOP;
		in_data1_i  = '0;
		in_data2_i  = '0;
		in_immd_i   = '0;
		in_tag_i    = '0;
		repeat (3) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;
		reset_and_latency();
		add_sub_carry();
		logic_ops();
		shift_ops();
		compare_ops();
		random_stream();
		$display("%0d instructions, %0d checks, %0d errors", op_count, check_count, error_count);
		if (error_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* all.f */
+incdir+test
src/exec_pkg.sv
src/exec_if.sv
src/issue_decode.sv
src/simple_alu.sv
src/writeback_buffer.sv
src/exec_lane_top.sv
test/exec_lane_tb.sv
